// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dma_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
source/dma_pkg.sv
source/dma_fifo.sv
source/dma_regs.sv
source/dma_arbiter.sv
source/dma_ctrl.sv
source/dma_wdt.sv
source/dma_ahbm_rd.sv
source/dma_ahbm_wr.sv
source/dma_core.sv
verification/dma_core_properties.sv
verification/dma_tb.sv

// ==== source/dma_ahbm_rd.sv ====
// AHB-Lite read master, single word transfers with address and data overlapped
// each good data beat goes straight into the FIFO
`timescale 1ns/10ps

module dma_ahbm_rd
   import dma_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  rd_start,
   input  logic [ADDR_W-1:0]     rd_addr,
   input  logic [BURST_BITS-1:0] burst_len,
   input  logic [DATA_W-1:0]     rhrdata,
   input  logic                  rhready,
   input  logic                  rhresp,
   output logic [ADDR_W-1:0]     rhaddr,
   output logic [1:0]            rhtrans,
   output logic                  fifo_push,
   output logic [DATA_W-1:0]     fifo_wdata,
   output logic                  rd_done,
   output logic                  rd_err,
   output logic                  rd_beat
);

   // address phases still to issue
   logic [BURST_BITS-1:0] addr_left;
   logic                  aphase;
   logic                  dphase;

   assign aphase     = (addr_left != '0);
   assign rhtrans    = aphase ? HTRANS_NONSEQ : HTRANS_IDLE;
   assign rd_beat    = dphase & rhready;
   assign rd_err     = rd_beat & rhresp;
   assign fifo_push  = rd_beat & ~rhresp;
   assign fifo_wdata = rhrdata;

   always_ff @(posedge clk) begin
      if (rst) begin
         addr_left <= '0;
         dphase    <= 1'b0;
         rd_done   <= 1'b0;
         rhaddr    <= '0;
      end else begin
         rd_done <= rd_beat & ~aphase;
         if (rd_start) begin
            addr_left <= burst_len;
            dphase    <= 1'b0;
            rhaddr    <= rd_addr;
         end else if (rhready) begin
            // low ready holds both phases
            dphase <= aphase;
            if (aphase) begin
               addr_left <= addr_left - 1'b1;
               rhaddr    <= rhaddr + ADDR_W'(4);
            end
         end
      end
   end

endmodule

// ==== source/dma_ahbm_wr.sv ====
// AHB-Lite write master, the mirror of the read master
// one FIFO word per address phase, held through its data phase
`timescale 1ns/10ps

module dma_ahbm_wr
   import dma_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  wr_start,
   input  logic [ADDR_W-1:0]     wr_addr,
   input  logic [BURST_BITS-1:0] burst_len,
   input  logic [DATA_W-1:0]     fifo_rdata,
   input  logic                  whready,
   input  logic                  whresp,
   output logic [ADDR_W-1:0]     whaddr,
   output logic [1:0]            whtrans,
   output logic [DATA_W-1:0]     whwdata,
   output logic                  fifo_pop,
   output logic                  wr_done,
   output logic                  wr_err,
   output logic                  wr_beat
);

   logic [BURST_BITS-1:0] addr_left;
   logic                  aphase;
   logic                  dphase;

   assign aphase   = (addr_left != '0);
   assign whtrans  = aphase ? HTRANS_NONSEQ : HTRANS_IDLE;
   assign wr_beat  = dphase & whready;
   assign wr_err   = wr_beat & whresp;
   assign fifo_pop = aphase & whready;

   always_ff @(posedge clk) begin
      if (rst) begin
         addr_left <= '0;
         dphase    <= 1'b0;
         wr_done   <= 1'b0;
         whaddr    <= '0;
      end else begin
         wr_done <= wr_beat & ~aphase;
         if (wr_start) begin
            addr_left <= burst_len;
            dphase    <= 1'b0;
            whaddr    <= wr_addr;
         end else if (whready) begin
            dphase <= aphase;
            if (aphase) begin
               addr_left <= addr_left - 1'b1;
               whaddr    <= whaddr + ADDR_W'(4);
            end
         end
      end
   end

   // write data for the beat whose address was just taken
   always_ff @(posedge clk) begin
      if (fifo_pop) begin
         whwdata <= fifo_rdata;
      end
   end

endmodule

// ==== source/dma_arbiter.sv ====
// picks the channel for the next burst
// top channel first when enabled, round robin otherwise
`timescale 1ns/10ps

module dma_arbiter
   import dma_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic [NUM_CH-1:0]  ch_ready,
   input  logic               prio_top,
   input  logic [CH_BITS-1:0] prio_top_num,
   input  logic               burst_end,
   output logic               grant_valid,
   output logic [CH_BITS-1:0] grant_num
);

   logic [CH_BITS-1:0] last;
   logic [CH_BITS-1:0] rr_num;
   logic [CH_BITS-1:0] next_num;

   // walk down so the nearest ready channel after last is kept
   always_comb begin
      rr_num = last;
      for (int k = NUM_CH; k >= 1; k--) begin
         if (ch_ready[last + CH_BITS'(k)]) begin
            rr_num = last + CH_BITS'(k);
         end
      end
   end

   assign next_num = (prio_top && ch_ready[prio_top_num]) ? prio_top_num : rr_num;

   // grant stays put until its burst is over
   always_ff @(posedge clk) begin
      if (rst) begin
         grant_valid <= 1'b0;
         grant_num   <= '0;
         last        <= CH_BITS'(NUM_CH - 1);
      end else if (burst_end) begin
         grant_valid <= 1'b0;
         last        <= grant_num;
      end else if (!grant_valid) begin
         grant_valid <= |ch_ready;
         grant_num   <= next_num;
      end
   end

endmodule

// ==== source/dma_core.sv ====
// top of the memory to memory dma engine
// APB for setup, one AHB-Lite port for reads and one for writes
`timescale 1ns/10ps

module dma_core
   import dma_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic [NUM_CH-1:0]   ch_start,
   input  logic                prio_top,
   input  logic [CH_BITS-1:0]  prio_top_num,
   input  logic                psel,
   input  logic                penable,
   input  logic [PADDR_W-1:0]  paddr,
   input  logic                pwrite,
   input  logic [31:0]         pwdata,
   input  logic [DATA_W-1:0]   rhrdata,
   input  logic                rhready,
   input  logic                rhresp,
   input  logic                whready,
   input  logic                whresp,
   output logic                idle,
   output logic [NUM_CH-1:0]   ch_int,
   output logic [31:0]         prdata,
   output logic                pslverr,
   output logic [ADDR_W-1:0]   rhaddr,
   output logic [1:0]          rhtrans,
   output logic [ADDR_W-1:0]   whaddr,
   output logic [1:0]          whtrans,
   output logic [DATA_W-1:0]   whwdata
);

   logic [NUM_CH-1:0]     ch_ready;
   logic                  grant_valid;
   logic [CH_BITS-1:0]    grant_num;
   logic [ADDR_W-1:0]     cur_src;
   logic [ADDR_W-1:0]     cur_dst;
   logic [LEN_W-1:0]      cur_len;
   logic                  rd_start;
   logic [ADDR_W-1:0]     rd_addr;
   logic                  wr_start;
   logic [ADDR_W-1:0]     wr_addr;
   logic [BURST_BITS-1:0] burst_len;
   logic [CH_BITS-1:0]    ch_num;
   logic                  burst_end;
   logic                  burst_abort;
   logic                  busy;
   logic                  fifo_flush;
   logic                  wdt_timeout;
   logic                  rd_done;
   logic                  rd_err;
   logic                  rd_beat;
   logic                  wr_done;
   logic                  wr_err;
   logic                  wr_beat;
   logic                  fifo_push;
   logic [DATA_W-1:0]     fifo_wdata;
   logic                  fifo_pop;
   logic [DATA_W-1:0]     fifo_rdata;
   logic                  beat;
   logic                  burst_done;
   logic                  master_rst;

   assign beat       = rd_beat | wr_beat;
   // the arbiter frees its grant on either way a burst can finish
   assign burst_done = burst_end | burst_abort;
   // an abort drops whatever the bus masters still have in flight
   assign master_rst = rst | fifo_flush;

   dma_regs    u_regs    (.*);
   dma_arbiter u_arbiter (.burst_end(burst_done), .*);
   dma_ctrl    u_ctrl    (.*);
   dma_wdt     u_wdt     (.*);
   dma_ahbm_rd u_ahbm_rd (.rst(master_rst), .*);
   dma_ahbm_wr u_ahbm_wr (.rst(master_rst), .*);
   dma_fifo    u_fifo    (.fifo_empty(), .*);

endmodule

// ==== source/dma_ctrl.sv ====
// sequences one burst of the granted channel
// read burst into the FIFO, then write burst out of it
`timescale 1ns/10ps

module dma_ctrl
   import dma_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  grant_valid,
   input  logic [CH_BITS-1:0]    grant_num,
   input  logic [ADDR_W-1:0]     cur_src,
   input  logic [ADDR_W-1:0]     cur_dst,
   input  logic [LEN_W-1:0]      cur_len,
   input  logic                  rd_done,
   input  logic                  wr_done,
   input  logic                  rd_err,
   input  logic                  wr_err,
   input  logic                  wdt_timeout,
   output logic                  rd_start,
   output logic [ADDR_W-1:0]     rd_addr,
   output logic                  wr_start,
   output logic [ADDR_W-1:0]     wr_addr,
   output logic [BURST_BITS-1:0] burst_len,
   output logic [CH_BITS-1:0]    ch_num,
   output logic                  burst_end,
   output logic                  burst_abort,
   output logic                  busy,
   output logic                  fifo_flush
);

   logic [2:0]        state;
   logic [ADDR_W-1:0] src_q;
   logic [ADDR_W-1:0] dst_q;
   logic [LEN_W-1:0]  len_q;
   logic              abort;

   assign abort     = rd_err | wr_err | wdt_timeout;
   assign rd_addr   = src_q;
   assign wr_addr   = dst_q;
   assign busy      = (state != ST_IDLE);
   assign burst_len = (len_q > LEN_W'(BURST_WORDS)) ? BURST_BITS'(BURST_WORDS)
                                                   : len_q[BURST_BITS-1:0];

   // snapshot of the channel for this burst
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && grant_valid) begin
         ch_num <= grant_num;
         src_q  <= cur_src;
         dst_q  <= cur_dst;
         len_q  <= cur_len;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= ST_IDLE;
         rd_start    <= 1'b0;
         wr_start    <= 1'b0;
         burst_end   <= 1'b0;
         burst_abort <= 1'b0;
         fifo_flush  <= 1'b0;
      end else begin
         rd_start    <= 1'b0;
         wr_start    <= 1'b0;
         burst_end   <= 1'b0;
         burst_abort <= 1'b0;
         fifo_flush  <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (grant_valid) begin
                  state <= ST_LOAD;
               end
            end
            ST_LOAD: begin
               rd_start <= 1'b1;
               state    <= ST_READ;
            end
            ST_READ, ST_WRITE: begin
               if (abort) begin
                  burst_abort <= 1'b1;
                  fifo_flush  <= 1'b1;
                  state       <= ST_END;
               end else if (state == ST_READ && rd_done) begin
                  wr_start <= 1'b1;
                  state    <= ST_WRITE;
               end else if (state == ST_WRITE && wr_done) begin
                  burst_end <= 1'b1;
                  state     <= ST_END;
               end
            end
            ST_END:  state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

// ==== source/dma_fifo.sv ====
// word FIFO between the read and write masters
// four entries hold one full burst, read side is first word fall through
`timescale 1ns/10ps

module dma_fifo (
   input  logic        clk,
   input  logic        rst,
   input  logic        fifo_flush,
   input  logic        fifo_push,
   input  logic [31:0] fifo_wdata,
   input  logic        fifo_pop,
   output logic [31:0] fifo_rdata,
   output logic        fifo_empty
);

   logic [31:0] mem [4];
   // extra top bit tells a full FIFO from an empty one
   logic [2:0]  wr_ptr;
   logic [2:0]  rd_ptr;

   assign fifo_empty = (wr_ptr == rd_ptr);
   assign fifo_rdata = mem[rd_ptr[1:0]];

   always_ff @(posedge clk) begin
      if (rst || fifo_flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (fifo_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (fifo_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fifo_push) begin
         mem[wr_ptr[1:0]] <= fifo_wdata;
      end
   end

endmodule

// ==== source/dma_pkg.sv ====
// sizes, register map, bus codes and controller states for the dma engine
// blocks pull these in with a wildcard import
package dma_pkg;

   localparam int NUM_CH      = 4;
   localparam int CH_BITS     = 2;
   localparam int ADDR_W      = 32;
   localparam int DATA_W      = 32;
   localparam int LEN_W       = 16;
   localparam int BURST_WORDS = 4;
   localparam int BURST_BITS  = 3;
   localparam int WDT_LIMIT   = 64;
   localparam int WDT_BITS    = 7;
   localparam int PADDR_W     = 8;

   // --------------------
   // per channel window, channel n starts at n*16
   localparam logic [3:0] REG_SRC  = 4'h0;
   localparam logic [3:0] REG_DST  = 4'h4;
   localparam logic [3:0] REG_LEN  = 4'h8;
   localparam logic [3:0] REG_STAT = 4'hc;

   localparam logic [PADDR_W-1:0] REG_INT = 8'h40;

   localparam logic [1:0] HTRANS_IDLE   = 2'b00;
   localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

   // --------------------
   localparam logic [2:0] ST_IDLE  = 3'd0;
   localparam logic [2:0] ST_LOAD  = 3'd1;
   localparam logic [2:0] ST_READ  = 3'd2;
   localparam logic [2:0] ST_WRITE = 3'd3;
   localparam logic [2:0] ST_END   = 3'd4;

endpackage

// ==== source/dma_regs.sv ====
// APB register file with per channel addresses, lengths and status
// also owns the interrupt bits and the idle flag
`timescale 1ns/10ps

module dma_regs
   import dma_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  psel,
   input  logic                  penable,
   input  logic [PADDR_W-1:0]    paddr,
   input  logic                  pwrite,
   input  logic [31:0]           pwdata,
   output logic [31:0]           prdata,
   output logic                  pslverr,
   input  logic [NUM_CH-1:0]     ch_start,
   input  logic [CH_BITS-1:0]    grant_num,
   input  logic                  burst_end,
   input  logic                  burst_abort,
   input  logic [CH_BITS-1:0]    ch_num,
   input  logic [BURST_BITS-1:0] burst_len,
   output logic [NUM_CH-1:0]     ch_ready,
   output logic [ADDR_W-1:0]     cur_src,
   output logic [ADDR_W-1:0]     cur_dst,
   output logic [LEN_W-1:0]      cur_len,
   output logic [NUM_CH-1:0]     ch_int,
   output logic                  idle
);

   logic [ADDR_W-1:0]  src [NUM_CH];
   logic [ADDR_W-1:0]  dst [NUM_CH];
   logic [LEN_W-1:0]   len [NUM_CH];
   logic [NUM_CH-1:0]  active;
   logic [NUM_CH-1:0]  err;
   logic               access;
   logic               apb_wr;
   logic               in_win;
   logic               is_int;
   logic [CH_BITS-1:0] sel_ch;
   logic [ADDR_W-1:0]  burst_bytes;
   logic [LEN_W-1:0]   burst_words;

   // --------------------
   // APB decode
   assign access  = psel & penable;
   assign apb_wr  = access & pwrite;
   assign sel_ch  = paddr[CH_BITS+3:4];
   assign in_win  = (paddr[PADDR_W-1:CH_BITS+4] == '0) && (paddr[1:0] == 2'b00);
   assign is_int  = (paddr == REG_INT);
   assign pslverr = access & ~(in_win | is_int);

   always_comb begin
      prdata = '0;
      if (is_int) begin
         prdata[NUM_CH-1:0] = ch_int;
      end else if (in_win) begin
         case (paddr[3:0])
            REG_SRC:  prdata = src[sel_ch];
            REG_DST:  prdata = dst[sel_ch];
            REG_LEN:  prdata[LEN_W-1:0] = len[sel_ch];
            REG_STAT: prdata[1:0] = {err[sel_ch], active[sel_ch]};
            default:  prdata = '0;
         endcase
      end
   end

   // --------------------
   assign burst_words = LEN_W'(burst_len);
   assign burst_bytes = ADDR_W'(burst_len) << 2;

   // burst progress wins over a software write in the same cycle
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_CH; i++) begin
         if (apb_wr && in_win && sel_ch == CH_BITS'(i)) begin
            case (paddr[3:0])
               REG_SRC: src[i] <= pwdata;
               REG_DST: dst[i] <= pwdata;
               REG_LEN: len[i] <= pwdata[LEN_W-1:0];
               default: ;
            endcase
         end
         if (burst_end && ch_num == CH_BITS'(i)) begin
            src[i] <= src[i] + burst_bytes;
            dst[i] <= dst[i] + burst_bytes;
            len[i] <= len[i] - burst_words;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         active <= '0;
         err    <= '0;
         ch_int <= '0;
      end else begin
         // write one to clear
         if (apb_wr && is_int) begin
            ch_int <= ch_int & ~pwdata[NUM_CH-1:0];
         end
         for (int i = 0; i < NUM_CH; i++) begin
            if (ch_start[i] && len[i] != '0) begin
               active[i] <= 1'b1;
               err[i]    <= 1'b0;
            end
            if (ch_num == CH_BITS'(i)) begin
               if (burst_end && len[i] == burst_words) begin
                  active[i] <= 1'b0;
                  ch_int[i] <= 1'b1;
               end
               if (burst_abort) begin
                  active[i] <= 1'b0;
                  err[i]    <= 1'b1;
                  ch_int[i] <= 1'b1;
               end
            end
         end
      end
   end

   // --------------------
   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         ch_ready[i] = active[i] & (len[i] != '0);
      end
   end

   assign cur_src = src[grant_num];
   assign cur_dst = dst[grant_num];
   assign cur_len = len[grant_num];
   assign idle    = ~|active;

endmodule

// ==== source/dma_wdt.sv ====
// watchdog for a stalled bus during a burst
// pulses once after WDT_LIMIT cycles with no completed beat
`timescale 1ns/10ps

module dma_wdt
   import dma_pkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic busy,
   input  logic beat,
   output logic wdt_timeout
);

   logic [WDT_BITS-1:0] cnt;

   always_ff @(posedge clk) begin
      if (rst || !busy || beat) begin
         cnt         <= '0;
         wdt_timeout <= 1'b0;
      end else if (cnt == WDT_BITS'(WDT_LIMIT - 1)) begin
         cnt         <= '0;
         wdt_timeout <= 1'b1;
      end else begin
         cnt         <= cnt + 1'b1;
         wdt_timeout <= 1'b0;
      end
   end

endmodule

// ==== verification/dma_core_properties.sv ====
// bus rule checks for the dma engine, bound into every dma_core
`timescale 1ns/10ps

module dma_core_properties
   import dma_pkg::*;
(
   input logic              clk,
   input logic              rst,
   input logic              idle,
   input logic [ADDR_W-1:0] rhaddr,
   input logic [1:0]        rhtrans,
   input logic [ADDR_W-1:0] whaddr,
   input logic [1:0]        whtrans
);

   logic bad_ports = 1'b0;
   logic bad_align = 1'b0;
   logic bad_idle  = 1'b0;

   // reads and writes take turns
   one_port_active: assert property (@(posedge clk) disable iff (rst)
      !(rhtrans == HTRANS_NONSEQ && whtrans == HTRANS_NONSEQ))
      else begin
         $error("read and write ports active in the same cycle");
         bad_ports = 1'b1;
      end

   word_aligned: assert property (@(posedge clk) disable iff (rst)
      (rhtrans != HTRANS_NONSEQ || rhaddr[1:0] == 2'b00) &&
      (whtrans != HTRANS_NONSEQ || whaddr[1:0] == 2'b00))
      else begin
         $error("bus address not word aligned");
         bad_align = 1'b1;
      end

   idle_quiet: assert property (@(posedge clk) disable iff (rst)
      idle |-> (rhtrans == HTRANS_IDLE && whtrans == HTRANS_IDLE))
      else begin
         $error("bus transfer while the engine is idle");
         bad_idle = 1'b1;
      end

endmodule

bind dma_core dma_core_properties u_props (
   .clk     (clk),
   .rst     (rst),
   .idle    (idle),
   .rhaddr  (rhaddr),
   .rhtrans (rhtrans),
   .whaddr  (whaddr),
   .whtrans (whtrans)
);

// ==== verification/dma_tb.sv ====
// directed testbench for the dma engine
// one process models both AHB slaves over a shared memory
// APB tasks set up the channels
`timescale 1ns/10ps

module dma_tb
   import dma_pkg::*;
();

   localparam int MEM_WORDS = 1024;

   logic                clk;
   logic                rst          = 1'b1;
   logic [NUM_CH-1:0]   ch_start     = '0;
   logic                prio_top     = 1'b0;
   logic [CH_BITS-1:0]  prio_top_num = '0;
   logic                psel         = 1'b0;
   logic                penable      = 1'b0;
   logic [PADDR_W-1:0]  paddr        = '0;
   logic                pwrite       = 1'b0;
   logic [31:0]         pwdata       = '0;
   logic [DATA_W-1:0]   rhrdata      = '0;
   logic                rhready      = 1'b1;
   logic                rhresp       = 1'b0;
   logic                whready      = 1'b1;
   logic                whresp       = 1'b0;
   logic                idle;
   logic [NUM_CH-1:0]   ch_int;
   logic [31:0]         prdata;
   logic                pslverr;
   logic [ADDR_W-1:0]   rhaddr;
   logic [1:0]          rhtrans;
   logic [ADDR_W-1:0]   whaddr;
   logic [1:0]          whtrans;
   logic [DATA_W-1:0]   whwdata;

   logic [31:0]         mem [MEM_WORDS];
   logic                wr_pend  = 1'b0;
   logic [ADDR_W-1:0]   wr_a     = '0;
   logic                rd_hold  = 1'b0;
   logic                err_en   = 1'b0;
   logic [ADDR_W-1:0]   err_addr = '0;
   int                  errors   = 0;
   int                  checks   = 0;
   int                  tests    = 0;

   dma_core UUT (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // every word starts out different, so a stray write shows up
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
   endfunction

   // fibonacci form with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [PADDR_W-1:0] reg_addr(input logic [CH_BITS-1:0] ch,
                                                    input logic [3:0] off);
      return PADDR_W'({ch, off});
   endfunction

   // --------------------
   // AHB slave models
   always @(posedge clk) begin : slave_models
      logic [31:0] lfsr;
      logic        rd_go;
      logic        wr_go;
      if (rst) begin
         for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i[9:0]] <= fill_word(32'(i) << 2);
         end
         lfsr = 32'h8debec16;
         rhready <= 1'b1;
         rhresp  <= 1'b0;
         whready <= 1'b1;
         wr_pend <= 1'b0;
      end else begin
         // wait state odds are one in four on each side
         lfsr = lfsr_next(lfsr);
         rd_go = lfsr[0];
         lfsr = lfsr_next(lfsr);
         rd_go = rd_go | lfsr[0];
         lfsr = lfsr_next(lfsr);
         wr_go = lfsr[0];
         lfsr = lfsr_next(lfsr);
         wr_go = wr_go | lfsr[0];
         if (rhready) begin
            rhrdata <= mem[rhaddr[11:2]];
            rhresp  <= err_en && rhtrans == HTRANS_NONSEQ && rhaddr == err_addr;
            rhready <= !rd_hold && (rhtrans == HTRANS_IDLE || rd_go);
         end else begin
            rhready <= !rd_hold && rd_go;
         end
         if (whready) begin
            if (wr_pend) begin
               mem[wr_a[11:2]] <= whwdata;
            end
            wr_pend <= (whtrans == HTRANS_NONSEQ);
            wr_a    <= whaddr;
            whready <= (whtrans == HTRANS_IDLE) || wr_go;
         end else begin
            whready <= wr_go;
         end
      end
   end

   // --------------------
   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH time %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errs_before);
      end
   endtask

   task automatic apb_write(input logic [PADDR_W-1:0] addr, input logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(input logic [PADDR_W-1:0] addr, output logic [31:0] data,
                           output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      data = prdata;
      err  = pslverr;
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic setup_channel(input logic [CH_BITS-1:0] ch, input logic [31:0] src,
                                input logic [31:0] dst, input logic [31:0] len);
      apb_write(reg_addr(ch, REG_SRC), src);
      apb_write(reg_addr(ch, REG_DST), dst);
      apb_write(reg_addr(ch, REG_LEN), len);
   endtask

   task automatic pulse_start(input logic [NUM_CH-1:0] mask);
      @(posedge clk);
      ch_start <= mask;
      @(posedge clk);
      ch_start <= '0;
   endtask

   task automatic wait_int(input logic [CH_BITS-1:0] ch, input int limit);
      int n;
      n = 0;
      while (!ch_int[ch] && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (!ch_int[ch]) begin
         errors++;
         $display("channel %0d interrupt did not arrive within %0d cycles", ch, limit);
      end
   endtask

   task automatic wait_idle(input int limit);
      int n;
      n = 0;
      while (!idle && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (!idle) begin
         errors++;
         $display("engine still busy after %0d cycles", limit);
      end
   endtask

   task automatic check_copy(input logic [31:0] src, input logic [31:0] dst, input int words);
      logic [31:0] a;
      for (int i = 0; i < words; i++) begin
         a = dst + 32'(i * 4);
         compare($sformatf("mem[%h]", a), mem[a[11:2]], fill_word(src + 32'(i * 4)));
      end
   endtask

   task automatic check_untouched(input logic [31:0] dst, input int words);
      logic [31:0] a;
      for (int i = 0; i < words; i++) begin
         a = dst + 32'(i * 4);
         compare($sformatf("mem[%h]", a), mem[a[11:2]], fill_word(a));
      end
   endtask

   // --------------------
   task automatic test_registers();
      int          e0;
      logic [31:0] rd;
      logic        err;
      e0 = errors;
      for (int c = 0; c < NUM_CH; c++) begin
         setup_channel(CH_BITS'(c), 32'h1000 + 32'(c) * 32'h100, 32'h2000 + 32'(c) * 32'h100,
                       32'(c + 3));
      end
      for (int c = 0; c < NUM_CH; c++) begin
         apb_read(reg_addr(CH_BITS'(c), REG_SRC), rd, err);
         compare("src", rd, 32'h1000 + 32'(c) * 32'h100);
         compare("pslverr", 32'(err), 32'd0);
         apb_read(reg_addr(CH_BITS'(c), REG_DST), rd, err);
         compare("dst", rd, 32'h2000 + 32'(c) * 32'h100);
         apb_read(reg_addr(CH_BITS'(c), REG_LEN), rd, err);
         compare("len", rd, 32'(c + 3));
      end
      apb_read(8'h44, rd, err);
      compare("pslverr at 44", 32'(err), 32'd1);
      apb_read(8'h41, rd, err);
      compare("pslverr at 41", 32'(err), 32'd1);
      apb_read(REG_INT, rd, err);
      compare("pslverr at 40", 32'(err), 32'd0);
      report_test("registers", e0);
   endtask

   task automatic test_single_copy();
      int          e0;
      logic [31:0] rd;
      logic        err;
      e0 = errors;
      setup_channel(2'd2, 32'h100, 32'h200, 32'd6);
      pulse_start(4'b0100);
      wait_int(2'd2, 2000);
      compare("idle", 32'(idle), 32'd1);
      check_copy(32'h100, 32'h200, 6);
      apb_read(reg_addr(2'd2, REG_STAT), rd, err);
      compare("ch2 status", rd, 32'd0);
      apb_write(REG_INT, 32'h4);
      apb_read(REG_INT, rd, err);
      compare("int register", rd, 32'd0);
      compare("ch_int", 32'(ch_int), 32'd0);
      report_test("single copy", e0);
   endtask

   task automatic test_priority();
      int e0;
      int n;
      e0 = errors;
      n  = 0;
      setup_channel(2'd0, 32'h300, 32'h400, 32'd8);
      setup_channel(2'd2, 32'h500, 32'h600, 32'd8);
      prio_top     <= 1'b1;
      prio_top_num <= 2'd2;
      pulse_start(4'b0101);
      while (whtrans != HTRANS_NONSEQ && n < 500) begin
         @(posedge clk);
         n++;
      end
      if (whtrans != HTRANS_NONSEQ) begin
         errors++;
         $display("no write transfer seen after both channels started");
      end
      // channel 2 was served last, so round robin alone would pick channel 0
      compare("whaddr block of first write", whaddr & ~32'h1f, 32'h600);
      wait_int(2'd2, 3000);
      wait_int(2'd0, 3000);
      wait_idle(100);
      check_copy(32'h500, 32'h600, 8);
      check_copy(32'h300, 32'h400, 8);
      prio_top <= 1'b0;
      apb_write(REG_INT, 32'hf);
      report_test("priority", e0);
   endtask

   task automatic test_bus_error();
      int          e0;
      logic [31:0] rd;
      logic        err;
      e0 = errors;
      err_en   <= 1'b1;
      err_addr <= 32'h710;
      setup_channel(2'd1, 32'h700, 32'h800, 32'd8);
      setup_channel(2'd3, 32'h900, 32'ha00, 32'd8);
      pulse_start(4'b1010);
      wait_int(2'd1, 3000);
      wait_int(2'd3, 3000);
      wait_idle(100);
      apb_read(reg_addr(2'd1, REG_STAT), rd, err);
      compare("ch1 status", rd, 32'h2);
      apb_read(reg_addr(2'd3, REG_STAT), rd, err);
      compare("ch3 status", rd, 32'd0);
      // the second burst of channel 1 hits the error
      check_copy(32'h700, 32'h800, 4);
      check_untouched(32'h810, 4);
      check_copy(32'h900, 32'ha00, 8);
      err_en <= 1'b0;
      apb_write(REG_INT, 32'hf);
      report_test("bus error", e0);
   endtask

   task automatic test_watchdog();
      int          e0;
      logic [31:0] rd;
      logic        err;
      e0 = errors;
      rd_hold <= 1'b1;
      setup_channel(2'd0, 32'hb00, 32'hc00, 32'd5);
      pulse_start(4'b0001);
      wait_int(2'd0, WDT_LIMIT + 16);
      compare("idle", 32'(idle), 32'd1);
      apb_read(reg_addr(2'd0, REG_STAT), rd, err);
      compare("ch0 status", rd, 32'h2);
      check_untouched(32'hc00, 5);
      rd_hold <= 1'b0;
      apb_write(REG_INT, 32'h1);
      pulse_start(4'b0001);
      wait_int(2'd0, 2000);
      check_copy(32'hb00, 32'hc00, 5);
      apb_read(reg_addr(2'd0, REG_STAT), rd, err);
      compare("ch0 status after restart", rd, 32'd0);
      apb_write(REG_INT, 32'hf);
      report_test("watchdog", e0);
   endtask

   // --------------------
   initial begin
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      compare("idle after reset", 32'(idle), 32'd1);
      compare("ch_int after reset", 32'(ch_int), 32'd0);
      compare("pslverr after reset", 32'(pslverr), 32'd0);
      compare("rhtrans after reset", 32'(rhtrans), 32'(HTRANS_IDLE));
      compare("whtrans after reset", 32'(whtrans), 32'(HTRANS_IDLE));
      test_registers();
      test_single_copy();
      test_priority();
      test_bus_error();
      test_watchdog();
      compare("assertion flags",
              32'({UUT.u_props.bad_ports, UUT.u_props.bad_align, UUT.u_props.bad_idle}),
              32'd0);
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule
